// File: verilog/ofm_pkg.sv
// ================================================
// Outbound frame path shared types and constants
// Stream beats, checksum command/result, FSM states
// ================================================
package ofm_pkg;

   // Data path geometry
   localparam int DATA_BYTES      = 8;
   localparam int BUF_DEPTH       = 512;
   localparam int BUF_AW          = 9;
   localparam int MAX_FRAME_WORDS = 256;
   localparam int RESULT_DEPTH    = 4;

   // Control frame layout
   localparam int       CTRL_WORDS   = 6;
   localparam bit [3:0] CTRL_FLAG_TX = 4'hA;
   localparam bit [1:0] CSUM_EN      = 2'b01;

   // 64-bit stream beat, tlast on top
   typedef struct packed {
      logic        tlast;
      logic [7:0]  tkeep;
      logic [63:0] tdata;
   } axis_data_t;

   // 32-bit control beat
   typedef struct packed {
      logic        tlast;
      logic [3:0]  tkeep;
      logic [31:0] tdata;
   } axis_ctrl_t;

   typedef struct packed {
      logic        enable;
      logic [15:0] start;
      logic [15:0] insert;
      logic [15:0] init;
   } csum_cmd_t;

   typedef struct packed {
      logic        enable;
      logic [15:0] insert;
      logic [15:0] csum;
   } csum_result_t;

   typedef enum logic [1:0] {
      ctrl_idle,
      ctrl_words,
      ctrl_hold
   } ctrl_state_t;

   typedef enum logic {
      tx_idle,
      tx_send
   } tx_state_t;

endpackage

// File: verilog/ofm_ctrl_parser.sv
// ================================================
// Control stream parser
// Turns six control words into one checksum command
// ================================================
`timescale 1ns/1ps

module ofm_ctrl_parser (
   input  logic                  tx_clk,
   input  logic                  reset,
   input  ofm_pkg::axis_ctrl_t   txc,
   input  logic                  txc_valid,
   input  logic                  cmd_done,
   output logic                  txc_ready,
   output ofm_pkg::csum_cmd_t    cmd,
   output logic                  cmd_valid
);

   ofm_pkg::ctrl_state_t state;
   logic [$clog2(ofm_pkg::CTRL_WORDS)-1:0] word_cnt;
   logic        txc_fire;
   logic        last_word;
   logic        cmd_enable;
   logic [3:0]  flag;
   logic [1:0]  csum_ctrl;
   logic [15:0] start_off;
   logic [15:0] insert_off;
   logic [15:0] init_val;

   // Control input closes while a command is held
   assign txc_ready = (state != ofm_pkg::ctrl_hold);
   assign cmd_valid = (state == ofm_pkg::ctrl_hold);
   assign txc_fire  = txc_valid && txc_ready;

   // tlast normally lands on word 5
   assign last_word = txc.tlast ||
                      (word_cnt == ($bits(word_cnt))'(ofm_pkg::CTRL_WORDS - 1));

   assign cmd = '{enable: cmd_enable,
                  start:  start_off,
                  insert: insert_off,
                  init:   init_val};

   always_ff @(posedge tx_clk) begin
      if (reset) begin
         state      <= ofm_pkg::ctrl_idle;
         word_cnt   <= '0;
         cmd_enable <= 1'b0;
      end else begin
         case (state)
            ofm_pkg::ctrl_idle,
            ofm_pkg::ctrl_words: begin
               if (txc_fire) begin
                  if (last_word) begin
                     state      <= ofm_pkg::ctrl_hold;
                     word_cnt   <= '0;
                     cmd_enable <= (flag == ofm_pkg::CTRL_FLAG_TX) &&
                                   (csum_ctrl == ofm_pkg::CSUM_EN);
                  end else begin
                     state    <= ofm_pkg::ctrl_words;
                     word_cnt <= word_cnt + 1'b1;
                  end
               end
            end
            ofm_pkg::ctrl_hold: begin
               // Released once the frame's last data beat is stored
               if (cmd_done)
                  state <= ofm_pkg::ctrl_idle;
            end
            default: state <= ofm_pkg::ctrl_idle;
         endcase
      end
   end

   // Field capture per word index
   always_ff @(posedge tx_clk) begin
      if (txc_fire) begin
         case (word_cnt)
            0: flag      <= txc.tdata[31:28];
            1: csum_ctrl <= txc.tdata[1:0];
            2: begin
               start_off  <= txc.tdata[31:16];
               insert_off <= txc.tdata[15:0];
            end
            3: init_val  <= txc.tdata[15:0];
            default: ;
         endcase
      end
   end

endmodule

// File: verilog/ofm_frame_buffer.sv
// ================================================
// Store-and-forward frame buffer
// Holds data beats and counts complete frames
// ================================================
`timescale 1ns/1ps

module ofm_frame_buffer (
   input  logic                  tx_clk,
   input  logic                  reset,
   input  ofm_pkg::axis_data_t   txd,
   input  logic                  txd_valid,
   input  logic                  cmd_valid,
   input  logic                  res_full,
   input  logic                  rd_en,
   output logic                  txd_ready,
   output logic                  cmd_done,
   output ofm_pkg::axis_data_t   wr_beat,
   output logic                  wr_en,
   output ofm_pkg::axis_data_t   rd_beat,
   output logic                  frame_avail
);

   ofm_pkg::axis_data_t mem [ofm_pkg::BUF_DEPTH];

   logic [ofm_pkg::BUF_AW-1:0] wr_ptr;
   logic [ofm_pkg::BUF_AW-1:0] rd_ptr;
   logic [ofm_pkg::BUF_AW:0]   fill;
   logic [ofm_pkg::BUF_AW:0]   frame_cnt;
   logic                       buf_full;
   logic                       rd_q;
   logic                       frame_in;
   logic                       frame_out;

   assign buf_full = (fill == (ofm_pkg::BUF_AW+1)'(ofm_pkg::BUF_DEPTH));

   // Accept data only against a held command
   assign txd_ready = cmd_valid && !res_full && !buf_full;
   assign wr_en     = txd_valid && txd_ready;
   assign wr_beat   = txd;
   assign cmd_done  = wr_en && txd.tlast;

   assign frame_in  = cmd_done;
   // Last beat leaves the read register one cycle after rd_en
   assign frame_out = rd_q && rd_beat.tlast;

   assign frame_avail = (frame_cnt != '0);

   always_ff @(posedge tx_clk) begin
      if (wr_en)
         mem[wr_ptr] <= txd;
      if (rd_en)
         rd_beat <= mem[rd_ptr];
   end

   always_ff @(posedge tx_clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         rd_q   <= 1'b0;
      end else begin
         rd_q <= rd_en;
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // Occupancy in beats
   always_ff @(posedge tx_clk) begin
      if (reset) begin
         fill <= '0;
      end else begin
         case ({wr_en, rd_en})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: ;
         endcase
      end
   end

   // Complete frames waiting to be sent
   always_ff @(posedge tx_clk) begin
      if (reset) begin
         frame_cnt <= '0;
      end else begin
         case ({frame_in, frame_out})
            2'b10:   frame_cnt <= frame_cnt + 1'b1;
            2'b01:   frame_cnt <= frame_cnt - 1'b1;
            default: ;
         endcase
      end
   end

endmodule

// File: verilog/ofm_csum_calc.sv
// ================================================
// Checksum calculator
// Sums frame bytes on the write side and queues results
// ================================================
`timescale 1ns/1ps

module ofm_csum_calc (
   input  logic                   tx_clk,
   input  logic                   reset,
   input  ofm_pkg::csum_cmd_t     cmd,
   input  ofm_pkg::axis_data_t    wr_beat,
   input  logic                   wr_en,
   input  logic                   res_pop,
   output logic                   res_full,
   output ofm_pkg::csum_result_t  result,
   output logic                   res_valid
);

   localparam int QAW = $clog2(ofm_pkg::RESULT_DEPTH);

   logic [$clog2(ofm_pkg::MAX_FRAME_WORDS)-1:0] word_cnt;
   logic [15:0] word_off;
   logic [3:0]  kept;
   logic [19:0] beat_sum;
   logic [16:0] base_sum;
   logic [16:0] run_sum;
   logic [19:0] total;
   logic [16:0] sum_next;
   logic [15:0] fold;
   logic [16:0] frame_len;
   logic [16:0] insert_end;
   logic        push;
   ofm_pkg::csum_result_t new_res;
   ofm_pkg::csum_result_t queue [ofm_pkg::RESULT_DEPTH];
   logic [QAW-1:0] q_wr;
   logic [QAW-1:0] q_rd;
   logic [QAW:0]   q_cnt;

   assign word_off = 16'(word_cnt) * 16'(ofm_pkg::DATA_BYTES);

   // Per-beat byte sum with pairing by distance from the start offset
   always_comb begin
      beat_sum = '0;
      kept     = '0;
      for (int i = 0; i < ofm_pkg::DATA_BYTES; i++) begin
         logic [15:0] off;
         off = word_off + 16'(i);
         if (wr_beat.tkeep[i]) begin
            kept = kept + 1'b1;
            if (off >= cmd.start) begin
               if (off[0] == cmd.start[0])
                  beat_sum = beat_sum + {4'b0, wr_beat.tdata[8*i +: 8], 8'h00};
               else
                  beat_sum = beat_sum + 20'(wr_beat.tdata[8*i +: 8]);
            end
         end
      end
   end

   // First beat starts from the initial value
   assign base_sum = (word_cnt == '0) ? {1'b0, cmd.init} : run_sum;
   assign total    = 20'(base_sum) + beat_sum;
   assign sum_next = 17'(total[15:0]) + 17'(total[19:16]);

   // End-around carry of the 17-bit sum
   assign fold = sum_next[15:0] + 16'(sum_next[16]);

   assign frame_len  = 17'(word_off) + 17'(kept);
   assign insert_end = 17'(cmd.insert) + 17'd1;

   assign new_res = '{enable: cmd.enable && (insert_end < frame_len),
                      insert: cmd.insert,
                      csum:   ~fold};

   assign push = wr_en && wr_beat.tlast;

   always_ff @(posedge tx_clk) begin
      if (reset) begin
         word_cnt <= '0;
      end else if (wr_en) begin
         word_cnt <= wr_beat.tlast ? '0 : word_cnt + 1'b1;
      end
   end

   always_ff @(posedge tx_clk) begin
      if (wr_en)
         run_sum <= sum_next;
      if (push)
         queue[q_wr] <= new_res;
   end

   // Result queue pointers
   always_ff @(posedge tx_clk) begin
      if (reset) begin
         q_wr  <= '0;
         q_rd  <= '0;
         q_cnt <= '0;
      end else begin
         if (push)
            q_wr <= q_wr + 1'b1;
         if (res_pop)
            q_rd <= q_rd + 1'b1;
         case ({push, res_pop})
            2'b10:   q_cnt <= q_cnt + 1'b1;
            2'b01:   q_cnt <= q_cnt - 1'b1;
            default: ;
         endcase
      end
   end

   assign res_full  = (q_cnt == (QAW+1)'(ofm_pkg::RESULT_DEPTH));
   assign res_valid = (q_cnt != '0);
   assign result    = queue[q_rd];

endmodule

// File: verilog/ofm_csum_insert.sv
// ================================================
// Checksum insert and MAC stream output
// Reads stored frames and patches in the checksum
// ================================================
`timescale 1ns/1ps

module ofm_csum_insert (
   input  logic                   tx_clk,
   input  logic                   reset,
   input  ofm_pkg::axis_data_t    rd_beat,
   input  logic                   frame_avail,
   input  ofm_pkg::csum_result_t  result,
   input  logic                   res_valid,
   input  logic                   mac_ready,
   output logic                   rd_en,
   output logic                   res_pop,
   output ofm_pkg::axis_data_t    mac,
   output logic                   mac_valid
);

   ofm_pkg::tx_state_t state;
   logic        pend;
   logic        last_seen;
   logic        out_free;
   logic        load;
   logic        mac_fire;
   logic [15:0] out_off;
   logic [15:0] insert_next;
   ofm_pkg::axis_data_t patched;

   // pend: rd_beat holds a beat not yet moved to the output
   assign out_free = !mac_valid || mac_ready;
   assign load     = pend && out_free;
   assign mac_fire = mac_valid && mac_ready;

   // Never read past the frame's last beat
   assign rd_en = (state == ofm_pkg::tx_send) && out_free && !last_seen &&
                  !(pend && rd_beat.tlast);

   assign res_pop = (state == ofm_pkg::tx_send) && mac_fire && mac.tlast;

   assign insert_next = result.insert + 16'd1;

   // Checksum bytes may straddle two beats
   always_comb begin
      patched = rd_beat;
      for (int i = 0; i < ofm_pkg::DATA_BYTES; i++) begin
         logic [15:0] off;
         off = out_off + 16'(i);
         if (result.enable && (off == result.insert))
            patched.tdata[8*i +: 8] = result.csum[15:8];
         if (result.enable && (off == insert_next))
            patched.tdata[8*i +: 8] = result.csum[7:0];
      end
   end

   always_ff @(posedge tx_clk) begin
      if (reset) begin
         state     <= ofm_pkg::tx_idle;
         pend      <= 1'b0;
         last_seen <= 1'b0;
         out_off   <= '0;
         mac_valid <= 1'b0;
      end else begin
         case (state)
            ofm_pkg::tx_idle: begin
               if (frame_avail && res_valid) begin
                  state     <= ofm_pkg::tx_send;
                  last_seen <= 1'b0;
                  out_off   <= '0;
               end
            end
            ofm_pkg::tx_send: begin
               if (res_pop)
                  state <= ofm_pkg::tx_idle;
            end
            default: state <= ofm_pkg::tx_idle;
         endcase

         pend <= rd_en || (pend && !load);

         if (load) begin
            out_off <= out_off + 16'(ofm_pkg::DATA_BYTES);
            if (rd_beat.tlast)
               last_seen <= 1'b1;
         end

         if (load)
            mac_valid <= 1'b1;
         else if (mac_ready)
            mac_valid <= 1'b0;
      end
   end

   always_ff @(posedge tx_clk) begin
      if (load)
         mac <= patched;
   end

endmodule

// File: verilog/axi_eth_ofm.sv
// ================================================
// Ethernet DMA transmit outbound frame path
// Control/data AXI-Stream in, checksummed MAC stream out
// ================================================
`timescale 1ns/1ps

module axi_eth_ofm (
   input  logic                  tx_clk,
   input  logic                  reset,
   input  ofm_pkg::axis_ctrl_t   txc,
   input  logic                  txc_valid,
   output logic                  txc_ready,
   input  ofm_pkg::axis_data_t   txd,
   input  logic                  txd_valid,
   output logic                  txd_ready,
   output ofm_pkg::axis_data_t   mac,
   output logic                  mac_valid,
   input  logic                  mac_ready
);

   ofm_pkg::csum_cmd_t    cmd;
   logic                  cmd_valid;
   logic                  cmd_done;
   ofm_pkg::axis_data_t   wr_beat;
   logic                  wr_en;
   ofm_pkg::axis_data_t   rd_beat;
   logic                  rd_en;
   logic                  frame_avail;
   ofm_pkg::csum_result_t result;
   logic                  res_valid;
   logic                  res_full;
   logic                  res_pop;

   ofm_ctrl_parser ctrl_parser0 (
      .tx_clk    (tx_clk),
      .reset     (reset),
      .txc       (txc),
      .txc_valid (txc_valid),
      .cmd_done  (cmd_done),
      .txc_ready (txc_ready),
      .cmd       (cmd),
      .cmd_valid (cmd_valid)
   );

   ofm_frame_buffer frame_buffer0 (
      .tx_clk      (tx_clk),
      .reset       (reset),
      .txd         (txd),
      .txd_valid   (txd_valid),
      .cmd_valid   (cmd_valid),
      .res_full    (res_full),
      .rd_en       (rd_en),
      .txd_ready   (txd_ready),
      .cmd_done    (cmd_done),
      .wr_beat     (wr_beat),
      .wr_en       (wr_en),
      .rd_beat     (rd_beat),
      .frame_avail (frame_avail)
   );

   // Sums beats as they are written into the buffer
   ofm_csum_calc csum_calc0 (
      .tx_clk    (tx_clk),
      .reset     (reset),
      .cmd       (cmd),
      .wr_beat   (wr_beat),
      .wr_en     (wr_en),
      .res_pop   (res_pop),
      .res_full  (res_full),
      .result    (result),
      .res_valid (res_valid)
   );

   ofm_csum_insert csum_insert0 (
      .tx_clk      (tx_clk),
      .reset       (reset),
      .rd_beat     (rd_beat),
      .frame_avail (frame_avail),
      .result      (result),
      .res_valid   (res_valid),
      .mac_ready   (mac_ready),
      .rd_en       (rd_en),
      .res_pop     (res_pop),
      .mac         (mac),
      .mac_valid   (mac_valid)
   );

endmodule

// File: verification/ofm_tb.sv
// ================================================
// Outbound frame path testbench
// File-driven frames, reference model, MAC beat compare
// ================================================
`timescale 1ns/1ps

module ofm_tb;

   logic                tx_clk;
   logic                reset;
   ofm_pkg::axis_ctrl_t txc;
   logic                txc_valid;
   logic                txc_ready;
   ofm_pkg::axis_data_t txd;
   logic                txd_valid;
   logic                txd_ready;
   ofm_pkg::axis_data_t mac;
   logic                mac_valid;
   logic                mac_ready;

   // Test table as read from the pattern file
   logic [127:0] name_q [$];
   logic [3:0]   flag_q [$];
   logic [1:0]   ctrl_q [$];
   logic [15:0]  start_q [$];
   logic [15:0]  insert_q [$];
   logic [15:0]  init_q [$];
   int           len_q [$];
   logic [15:0]  csum_q [$];

   // Expected MAC beats and the test each one belongs to
   ofm_pkg::axis_data_t exp_q [$];
   int                  exp_test_q [$];

   integer seed = 32'heed01a9c;
   int     cycles = 0;
   int     cycle_limit = 2000;
   bit     first_in = 1'b0;

   axi_eth_ofm dut0 (
      .tx_clk    (tx_clk),
      .reset     (reset),
      .txc       (txc),
      .txc_valid (txc_valid),
      .txc_ready (txc_ready),
      .txd       (txd),
      .txd_valid (txd_valid),
      .txd_ready (txd_ready),
      .mac       (mac),
      .mac_valid (mac_valid),
      .mac_ready (mac_ready)
   );

   initial begin
      tx_clk = 1'b0;
      forever #4 tx_clk = ~tx_clk;
   end

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TEST FAIL");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_beat(input logic [127:0] tname, input ofm_pkg::axis_data_t exp,
                             input ofm_pkg::axis_data_t act);
      if (act !== exp) begin
         $display("error %0s expected %h actual %h", tname, exp, act);
         abort_run("MAC output beat differs from the expected frame");
      end
   endtask

   task automatic check_result(input logic [127:0] tname, input ofm_pkg::csum_result_t exp,
                               input ofm_pkg::csum_result_t act);
      if (act !== exp) begin
         $display("error %0s expected %h actual %h", tname, exp, act);
         abort_run("reference checksum differs from the pattern file");
      end
   endtask

   task automatic check_level(input string what, input logic exp, input logic act);
      if (act !== exp) begin
         $display("error %s expected %b actual %b", what, exp, act);
         abort_run("output level wrong");
      end
   endtask

   // Ones-complement sum from the start offset, even distance is the high byte
   function automatic logic [15:0] ref_checksum(input int start, input logic [15:0] init,
                                                input int len);
      logic [31:0] acc;
      acc = 32'(init);
      for (int k = start; k < len; k++) begin
         if (((k - start) % 2) == 0)
            acc = acc + 32'((k % 256) << 8);
         else
            acc = acc + 32'(k % 256);
      end
      while (acc[31:16] != 16'h0)
         acc = 32'(acc[15:0]) + 32'(acc[31:16]);
      return ~acc[15:0];
   endfunction

   // Frame byte k carries k mod 256
   function automatic ofm_pkg::axis_data_t make_beat(input int len, input int w);
      ofm_pkg::axis_data_t beat;
      int off;
      beat = '0;
      for (int i = 0; i < ofm_pkg::DATA_BYTES; i++) begin
         off = w * ofm_pkg::DATA_BYTES + i;
         if (off < len) begin
            beat.tdata[8*i +: 8] = 8'(off % 256);
            beat.tkeep[i]        = 1'b1;
         end
      end
      beat.tlast = ((w + 1) * ofm_pkg::DATA_BYTES >= len);
      return beat;
   endfunction

   task automatic build_expected(input int t);
      ofm_pkg::axis_data_t   beat;
      ofm_pkg::csum_result_t want;
      ofm_pkg::csum_result_t got;
      logic [15:0] csum;
      int          len;
      int          ins;
      int          off;
      bit          patch;
      len   = len_q[t];
      ins   = int'(insert_q[t]);
      patch = (flag_q[t] == 4'hA) && (ctrl_q[t] == 2'b01) && (ins + 1 < len);
      csum  = ref_checksum(int'(start_q[t]), init_q[t], len);
      if (patch) begin
         want = '{enable: 1'b1, insert: insert_q[t], csum: csum_q[t]};
         got  = '{enable: 1'b1, insert: insert_q[t], csum: csum};
         check_result(name_q[t], want, got);
      end
      for (int w = 0; w < (len + 7) / 8; w++) begin
         beat = make_beat(len, w);
         for (int i = 0; i < ofm_pkg::DATA_BYTES; i++) begin
            off = w * ofm_pkg::DATA_BYTES + i;
            if (patch && off == ins)
               beat.tdata[8*i +: 8] = csum[15:8];
            if (patch && off == ins + 1)
               beat.tdata[8*i +: 8] = csum[7:0];
         end
         exp_q.push_back(beat);
         exp_test_q.push_back(t);
      end
   endtask

   // Called on a falling edge, returns on the falling edge after acceptance
   task automatic send_ctrl_word(input logic [31:0] data, input logic last);
      bit taken;
      txc       = '{tlast: last, tkeep: 4'hF, tdata: data};
      txc_valid = 1'b1;
      do begin
         taken = txc_ready;
         @(negedge tx_clk);
      end while (!taken);
      txc_valid = 1'b0;
   endtask

   task automatic send_data_beat(input ofm_pkg::axis_data_t beat);
      bit taken;
      txd       = beat;
      txd_valid = 1'b1;
      do begin
         taken = txd_ready;
         @(negedge tx_clk);
      end while (!taken);
      txd_valid = 1'b0;
   endtask

   task automatic drive_ctrl();
      for (int t = 0; t < name_q.size(); t++) begin
         send_ctrl_word({flag_q[t], 28'h0}, 1'b0);
         send_ctrl_word({30'h0, ctrl_q[t]}, 1'b0);
         send_ctrl_word({start_q[t], insert_q[t]}, 1'b0);
         send_ctrl_word({16'h0, init_q[t]}, 1'b0);
         send_ctrl_word(32'h0, 1'b0);
         send_ctrl_word(32'h0, 1'b1);
      end
   endtask

   task automatic drive_data();
      for (int t = 0; t < name_q.size(); t++) begin
         for (int w = 0; w < (len_q[t] + 7) / 8; w++)
            send_data_beat(make_beat(len_q[t], w));
         first_in = 1'b1;
      end
   endtask

   // Random back-pressure and output compare on the falling edge
   always @(negedge tx_clk) begin
      mac_ready = (($random(seed) & 3) != 0);
      if (!reset && mac_valid && !first_in)
         abort_run("MAC output went valid before the first frame was stored");
      else if (mac_valid && mac_ready) begin
         if (exp_q.size() == 0)
            abort_run("unexpected beat on the MAC output");
         else begin
            check_beat(name_q[exp_test_q[0]], exp_q[0], mac);
            void'(exp_q.pop_front());
            void'(exp_test_q.pop_front());
         end
      end
   end

   always @(posedge tx_clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit)
         abort_run($sformatf("timeout after %0d cycles, not all frames left the DUT", cycles));
   end

   initial begin
      int           fd;
      int           n;
      int           total_words;
      string        line;
      logic [127:0] tname;
      logic [3:0]   flag;
      logic [1:0]   ctrl;
      logic [15:0]  start;
      logic [15:0]  ins;
      logic [15:0]  init;
      int           len;
      logic [15:0]  csum;
      reset       = 1'b1;
      txc         = '0;
      txc_valid   = 1'b0;
      txd         = '0;
      txd_valid   = 1'b0;
      mac_ready   = 1'b0;
      total_words = 0;
      fd = $fopen("verification/ofm_patterns.txt", "r");
      if (fd == 0)
         abort_run("cannot open the pattern file");
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (n > 0 && line.len() > 1 && line[0] != "#") begin
            n = $sscanf(line, "%s %h %h %h %h %h %d %h",
                        tname, flag, ctrl, start, ins, init, len, csum);
            if (n != 8 || len < 1 || len > 8 * ofm_pkg::MAX_FRAME_WORDS)
               abort_run("bad line in the pattern file");
            else begin
               name_q.push_back(tname);
               flag_q.push_back(flag);
               ctrl_q.push_back(ctrl);
               start_q.push_back(start);
               insert_q.push_back(ins);
               init_q.push_back(init);
               len_q.push_back(len);
               csum_q.push_back(csum);
            end
         end
      end
      $fclose(fd);
      if (name_q.size() == 0)
         abort_run("the pattern file holds no tests");
      for (int t = 0; t < name_q.size(); t++) begin
         build_expected(t);
         total_words += (len_q[t] + 7) / 8 + ofm_pkg::CTRL_WORDS;
      end
      cycle_limit = 4 * total_words + 2000;

      repeat (8) @(negedge tx_clk);
      reset = 1'b0;
      check_level("txc_ready after reset", 1'b1, txc_ready);
      check_level("txd_ready after reset", 1'b0, txd_ready);
      check_level("mac_valid after reset", 1'b0, mac_valid);

      fork
         drive_ctrl();
         drive_data();
      join
      while (exp_q.size() != 0)
         @(negedge tx_clk);
      // No trailing beats once every frame has been matched
      repeat (16) begin
         @(negedge tx_clk);
         check_level("mac_valid after the last frame", 1'b0, mac_valid);
      end
      $display("TEST PASS");
      $finish;
   end

endmodule

// File: src.f
verilog/ofm_pkg.sv
verilog/ofm_ctrl_parser.sv
verilog/ofm_frame_buffer.sv
verilog/ofm_csum_calc.sv
verilog/ofm_csum_insert.sv
verilog/axi_eth_ofm.sv
verification/ofm_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := ofm_tb
FILELIST := src.f
OBJ_DIR  := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the simulation prints the pass message
run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: verification/ofm_patterns.txt
# name flag ctrl start insert init length csum
# flag, ctrl, start, insert, init and csum in hex, length in decimal bytes, csum 0000 if unpatched
pass_256 a 0 0000 0000 0000 256 0000
pass_259 a 0 0000 0000 0000 259 0000
pass_272 a 0 0000 0000 0000 272 0000
csum_basic a 1 0015 0040 000f 100 96c3
csum_straddle a 1 0003 0007 0000 61 795c
b2b_init a 1 0000 000a 1234 40 703a
b2b_short a 1 000e 000e 0000 34 190f
b2b_tiny a 1 0001 0004 0100 9 eeeb
insert_tail a 1 0008 000e 0000 16 d3cf
pass_single a 0 0000 0000 0000 5 0000
bad_flag 5 1 0000 000a 0000 64 0000
insert_past a 1 0000 003f 0000 64 0000
ctrl_other a 2 0000 0004 0000 24 0000
csum_repeat a 1 0015 0040 000f 100 96c3
